// ==== project.f ====
common/wb_cmd_pkg.sv
source/wb_cmd_master.sv
source/wb_rr_arbiter.sv
source/wb_reg_bank.sv
source/wb_cmd_subsystem.sv
bench/tb_wb_cmd_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_wb_cmd_subsystem \
    -f project.f \
    --Mdir obj_dir

./obj_dir/Vtb_wb_cmd_subsystem | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== bench/tb_wb_cmd_subsystem.sv ====
`timescale 1ns/1ns

module tb_wb_cmd_subsystem;

    localparam int ADDR_BITS  = 25;
    localparam int REG_WORDS  = 16;
    localparam int WAIT_LIMIT = 200;
    localparam int RUN_LIMIT  = 20000;

    logic aclk;
    logic aresetn;

    // index 0 is lane a and index 1 is lane b
    logic [wb_cmd_pkg::WB_ADR_W-1:0]  addr_tdata [2];
    logic [1:0]                       addr_tvalid;
    logic [1:0]                       addr_tready;
    logic [wb_cmd_pkg::WB_DATA_W-1:0] data_tdata [2];
    logic [1:0]                       data_tvalid;
    logic [1:0]                       data_tready;
    logic [wb_cmd_pkg::WB_DATA_W-1:0] resp_tdata [2];
    logic [1:0]                       resp_tvalid;
    logic [1:0]                       resp_tready;

    // reference model state and expected read words per lane
    logic [wb_cmd_pkg::WB_DATA_W-1:0] model_regs [REG_WORDS];
    logic [wb_cmd_pkg::WB_DATA_W-1:0] last_read [2];
    logic [wb_cmd_pkg::WB_DATA_W-1:0] exp_a [$];
    logic [wb_cmd_pkg::WB_DATA_W-1:0] exp_b [$];
    int done_order [$];

    int   cmds_sent [2];
    int   writes_sent [2];
    int   addr_taken [2];
    int   data_taken [2];
    int   checks;
    int   errors;
    int   timeouts;
    logic timeout_hit;
    logic run_done;
    logic b_done;

    wb_cmd_subsystem #(
        .ADDR_BITS (ADDR_BITS),
        .REG_WORDS (REG_WORDS)
    ) wb_cmd_subsystem_inst (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .a_addr_tdata_i  (addr_tdata[0]),
        .a_addr_tvalid_i (addr_tvalid[0]),
        .a_addr_tready_o (addr_tready[0]),
        .a_data_tdata_i  (data_tdata[0]),
        .a_data_tvalid_i (data_tvalid[0]),
        .a_data_tready_o (data_tready[0]),
        .a_resp_tdata_o  (resp_tdata[0]),
        .a_resp_tvalid_o (resp_tvalid[0]),
        .a_resp_tready_i (resp_tready[0]),
        .b_addr_tdata_i  (addr_tdata[1]),
        .b_addr_tvalid_i (addr_tvalid[1]),
        .b_addr_tready_o (addr_tready[1]),
        .b_data_tdata_i  (data_tdata[1]),
        .b_data_tvalid_i (data_tvalid[1]),
        .b_data_tready_o (data_tready[1]),
        .b_resp_tdata_o  (resp_tdata[1]),
        .b_resp_tvalid_o (resp_tvalid[1]),
        .b_resp_tready_i (resp_tready[1])
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // an unmapped index repeats the lane's last read
    function automatic logic [wb_cmd_pkg::WB_DATA_W-1:0] expected_read(
        input int lane, input logic [wb_cmd_pkg::WB_ADR_W-1:0] addr_word);
        int idx;
        idx = int'(addr_word[ADDR_BITS-1:2]);
        if (idx < REG_WORDS) begin
            last_read[lane] = model_regs[idx];
        end
        return last_read[lane];
    endfunction

    // writes carry all byte selects and unmapped writes store nothing
    function automatic void model_write(input logic [wb_cmd_pkg::WB_ADR_W-1:0] addr_word,
                                        input logic [wb_cmd_pkg::WB_DATA_W-1:0] data_word);
        int idx;
        idx = int'(addr_word[ADDR_BITS-1:2]);
        if (idx < REG_WORDS) begin
            model_regs[idx] = data_word;
        end
    endfunction

    // junk fills the low two bits and the bits above ADDR_BITS
    function automatic logic [wb_cmd_pkg::WB_ADR_W-1:0] make_addr(input bit rd, input int idx,
                                                                 input logic [31:0] junk);
        logic [wb_cmd_pkg::WB_ADR_W-1:0] a;
        a = junk;
        a[wb_cmd_pkg::RD_FLAG_BIT] = rd;
        a[ADDR_BITS-1:2] = idx[ADDR_BITS-3:0];
        return a;
    endfunction

    function automatic logic [wb_cmd_pkg::WB_DATA_W-1:0] pop_expected(input int lane);
        if (lane == 0) begin
            return exp_a.pop_front();
        end
        return exp_b.pop_front();
    endfunction

    task automatic check_resp(input int lane, input logic [wb_cmd_pkg::WB_DATA_W-1:0] got,
                              input logic [wb_cmd_pkg::WB_DATA_W-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error at %0t ns: lane %0d response %h, expected %h",
                     $time, lane, got, expected);
        end
    endtask

    task automatic check_idle(input string what, input int lane, input logic got,
                              input logic expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error at %0t ns: lane %0d %s is %b, expected %b",
                     $time, lane, what, got, expected);
        end
    endtask

    task automatic check_count(input string what, input int lane, input int got,
                               input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("error at %0t ns: lane %0d %s %0d, expected %0d",
                     $time, lane, what, got, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        timeout_hit = 1'b1;
        $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic send_cmd(input int lane, input logic [wb_cmd_pkg::WB_ADR_W-1:0] addr_word,
                            input logic [wb_cmd_pkg::WB_DATA_W-1:0] data_word);
        int waited;
        addr_tdata[lane] = addr_word;
        addr_tvalid[lane] = 1'b1;
        cmds_sent[lane]++;
        if (addr_word[wb_cmd_pkg::RD_FLAG_BIT]) begin
            if (lane == 0) begin
                exp_a.push_back(expected_read(lane, addr_word));
            end else begin
                exp_b.push_back(expected_read(lane, addr_word));
            end
        end else begin
            data_tdata[lane] = data_word;
            data_tvalid[lane] = 1'b1;
            writes_sent[lane]++;
            model_write(addr_word, data_word);
        end
        waited = 0;
        @(negedge aclk);
        while (!addr_tready[lane] && waited < WAIT_LIMIT) begin
            @(negedge aclk);
            waited++;
        end
        if (!addr_tready[lane]) begin
            report_timeout($sformatf("lane %0d address handshake", lane));
        end
        @(posedge aclk);
        #1;
        addr_tvalid[lane] = 1'b0;
        data_tvalid[lane] = 1'b0;
    endtask

    task automatic run_random(input int lane, input int base, input int count,
                              input int max_gap, input bit reads_only);
        bit rd;
        int idx;
        for (int i = 0; i < count; i++) begin
            rd = reads_only || ($urandom_range(1, 0) == 1);
            idx = base + int'($urandom_range(REG_WORDS / 2 - 1, 0));
            send_cmd(lane, make_addr(rd, idx, $urandom), $urandom);
            repeat ($urandom_range(max_gap, 0)) begin
                @(posedge aclk);
                #1;
            end
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((exp_a.size() != 0 || exp_b.size() != 0) && waited < WAIT_LIMIT) begin
            @(negedge aclk);
            waited++;
        end
        if (exp_a.size() != 0 || exp_b.size() != 0) begin
            report_timeout("delivery of all read responses");
        end
        @(posedge aclk);
        #1;
    endtask

    // handshakes are sampled mid-cycle and transfer at the next rising edge
    always @(negedge aclk) begin
        if (aresetn) begin
            for (int l = 0; l < 2; l++) begin
                if (addr_tvalid[l] && addr_tready[l]) begin
                    addr_taken[l]++;
                end
                if (data_tvalid[l] && data_tready[l]) begin
                    data_taken[l]++;
                end
                if (resp_tvalid[l] && resp_tready[l]) begin
                    done_order.push_back(l);
                    if (((l == 0) ? exp_a.size() : exp_b.size()) == 0) begin
                        errors++;
                        $display("error at %0t ns: lane %0d response with no read pending",
                                 $time, l);
                    end else begin
                        check_resp(l, resp_tdata[l], pop_expected(l));
                    end
                end
            end
        end
    end

    initial begin
        int hold;
        int waited;
        int run;
        int worst;
        logic [wb_cmd_pkg::WB_DATA_W-1:0] wr_word;
        void'($urandom(32'h4499e2e0));
        aresetn = 1'b0;
        addr_tvalid = 2'b00;
        data_tvalid = 2'b00;
        resp_tready = 2'b11;
        timeout_hit = 1'b0;
        run_done = 1'b0;
        b_done = 1'b0;
        for (int l = 0; l < 2; l++) begin
            addr_tdata[l] = '0;
            data_tdata[l] = '0;
            last_read[l] = '0;
        end
        for (int i = 0; i < REG_WORDS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        // quiet outputs after reset and registers that read as zero
        @(negedge aclk);
        for (int l = 0; l < 2; l++) begin
            check_idle("addr_tready", l, addr_tready[l], 1'b0);
            check_idle("data_tready", l, data_tready[l], 1'b0);
            check_idle("resp_tvalid", l, resp_tvalid[l], 1'b0);
        end
        @(posedge aclk);
        #1;
        for (int i = 0; i < 4; i++) begin
            send_cmd(0, make_addr(1'b1, i * 3, $urandom), '0);
            send_cmd(1, make_addr(1'b1, REG_WORDS - 1 - i, $urandom), '0);
        end

        // write then read back with junk in the ignored address bits
        wr_word = $urandom;
        send_cmd(0, make_addr(1'b0, 5, 32'h7fff_ffff), wr_word);
        send_cmd(0, make_addr(1'b1, 5, 32'h2a5a_0001), '0);

        // unmapped reads repeat the lane's last read and unmapped writes change nothing
        send_cmd(0, make_addr(1'b1, REG_WORDS + int'($urandom_range(100, 0)), $urandom), '0);
        send_cmd(1, make_addr(1'b1, REG_WORDS + 3, $urandom), '0);
        send_cmd(0, make_addr(1'b0, REG_WORDS + 7, $urandom), $urandom);
        for (int i = 0; i < REG_WORDS; i++) begin
            send_cmd(0, make_addr(1'b1, i, $urandom), '0);
        end

        // both lanes at once with each on its own half of the bank
        fork
            run_random(0, 0, 40, 2, 1'b0);
            run_random(1, REG_WORDS / 2, 40, 2, 1'b0);
        join
        wait_drained();

        // lane a stalls its response while lane b keeps using the bus
        wr_word = $urandom;
        send_cmd(0, make_addr(1'b0, 3, $urandom), wr_word);
        resp_tready[0] = 1'b0;
        send_cmd(0, make_addr(1'b1, 3, $urandom), '0);
        hold = $urandom_range(20, 6);
        b_done = 1'b0;
        fork
            begin
                run_random(1, REG_WORDS / 2, 6, 1, 1'b0);
                b_done = 1'b1;
            end
            begin
                waited = 0;
                while ((waited < hold || !b_done) && waited < WAIT_LIMIT) begin
                    @(negedge aclk);
                    check_idle("resp_tvalid under back-pressure", 0, resp_tvalid[0], 1'b1);
                    check_resp(0, resp_tdata[0], wr_word);
                    waited++;
                end
                if (!b_done) begin
                    report_timeout("lane b progress while lane a is stalled");
                end
                @(posedge aclk);
                #1;
                resp_tready[0] = 1'b1;
            end
        join
        wait_drained();

        // back-to-back reads on both lanes should complete in turn
        done_order.delete();
        fork
            run_random(0, 0, 12, 0, 1'b1);
            run_random(1, REG_WORDS / 2, 12, 0, 1'b1);
        join
        wait_drained();
        run = 0;
        worst = 0;
        for (int i = 0; i < done_order.size(); i++) begin
            if (i > 0 && done_order[i] == done_order[i - 1]) begin
                run++;
            end else begin
                run = 1;
            end
            if (run > worst) begin
                worst = run;
            end
        end
        checks++;
        if (worst > 2) begin
            errors++;
            $display("error at %0t ns: one lane completed %0d reads in a row", $time, worst);
        end

        for (int l = 0; l < 2; l++) begin
            check_count("address words taken", l, addr_taken[l], cmds_sent[l]);
            check_count("data words taken", l, data_taken[l], writes_sent[l]);
        end
        run_done = 1'b1;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (!run_done && !timeout_hit && cycles < RUN_LIMIT) begin
            @(posedge aclk);
            cycles++;
        end
        if (!run_done && !timeout_hit) begin
            timeouts++;
            timeout_hit = 1'b1;
            $display("timeout: the test sequence did not finish within %0d cycles",
                     RUN_LIMIT);
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && !timeout_hit) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== source/wb_cmd_subsystem.sv ====
`timescale 1ns/1ns

// two link lanes sharing one register bank over Wishbone
module wb_cmd_subsystem #(
    parameter int ADDR_BITS = 25,
    parameter int REG_WORDS = 16
) (
    input  logic                             aclk,
    input  logic                             aresetn,

    // lane a
    input  logic [wb_cmd_pkg::WB_ADR_W-1:0]  a_addr_tdata_i,
    input  logic                             a_addr_tvalid_i,
    output logic                             a_addr_tready_o,
    input  logic [wb_cmd_pkg::WB_DATA_W-1:0] a_data_tdata_i,
    input  logic                             a_data_tvalid_i,
    output logic                             a_data_tready_o,
    output logic [wb_cmd_pkg::WB_DATA_W-1:0] a_resp_tdata_o,
    output logic                             a_resp_tvalid_o,
    input  logic                             a_resp_tready_i,

    // lane b
    input  logic [wb_cmd_pkg::WB_ADR_W-1:0]  b_addr_tdata_i,
    input  logic                             b_addr_tvalid_i,
    output logic                             b_addr_tready_o,
    input  logic [wb_cmd_pkg::WB_DATA_W-1:0] b_data_tdata_i,
    input  logic                             b_data_tvalid_i,
    output logic                             b_data_tready_o,
    output logic [wb_cmd_pkg::WB_DATA_W-1:0] b_resp_tdata_o,
    output logic                             b_resp_tvalid_o,
    input  logic                             b_resp_tready_i
);

    wb_cmd_pkg::wb_req_t req_a;
    wb_cmd_pkg::wb_req_t req_b;
    wb_cmd_pkg::wb_req_t bus_req;
    wb_cmd_pkg::wb_rsp_t rsp_a;
    wb_cmd_pkg::wb_rsp_t rsp_b;
    wb_cmd_pkg::wb_rsp_t bus_rsp;

    wb_cmd_master #(.ADDR_BITS(ADDR_BITS)) lane_a_master (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .addr_tdata_i  (a_addr_tdata_i),
        .addr_tvalid_i (a_addr_tvalid_i),
        .addr_tready_o (a_addr_tready_o),
        .data_tdata_i  (a_data_tdata_i),
        .data_tvalid_i (a_data_tvalid_i),
        .data_tready_o (a_data_tready_o),
        .resp_tdata_o  (a_resp_tdata_o),
        .resp_tvalid_o (a_resp_tvalid_o),
        .resp_tready_i (a_resp_tready_i),
        .wb_req_o      (req_a),
        .wb_rsp_i      (rsp_a)
    );

    wb_cmd_master #(.ADDR_BITS(ADDR_BITS)) lane_b_master (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .addr_tdata_i  (b_addr_tdata_i),
        .addr_tvalid_i (b_addr_tvalid_i),
        .addr_tready_o (b_addr_tready_o),
        .data_tdata_i  (b_data_tdata_i),
        .data_tvalid_i (b_data_tvalid_i),
        .data_tready_o (b_data_tready_o),
        .resp_tdata_o  (b_resp_tdata_o),
        .resp_tvalid_o (b_resp_tvalid_o),
        .resp_tready_i (b_resp_tready_i),
        .wb_req_o      (req_b),
        .wb_rsp_i      (rsp_b)
    );

    wb_rr_arbiter bus_arbiter (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req_a_i   (req_a),
        .req_b_i   (req_b),
        .rsp_a_o   (rsp_a),
        .rsp_b_o   (rsp_b),
        .bus_req_o (bus_req),
        .bus_rsp_i (bus_rsp)
    );

    wb_reg_bank #(
        .ADDR_BITS (ADDR_BITS),
        .REG_WORDS (REG_WORDS)
    ) regs (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .bus_req_i (bus_req),
        .bus_rsp_o (bus_rsp)
    );

endmodule

// ==== source/wb_reg_bank.sv ====
`timescale 1ns/1ns

// Wishbone register slave with REG_WORDS 32-bit words
// word indexes past the end answer with err and store nothing
module wb_reg_bank #(
    parameter int ADDR_BITS = 25,
    parameter int REG_WORDS = 16
) (
    input  logic                aclk,
    input  logic                aresetn,

    input  wb_cmd_pkg::wb_req_t bus_req_i,
    output wb_cmd_pkg::wb_rsp_t bus_rsp_o
);

    localparam int WORD_W = ADDR_BITS - 2;
    localparam int IDX_W  = (REG_WORDS > 1) ? $clog2(REG_WORDS) : 1;

    logic [wb_cmd_pkg::WB_DATA_W-1:0] regs [REG_WORDS];

    logic [WORD_W-1:0] word_idx;
    logic [IDX_W-1:0]  reg_idx;
    logic              in_range;
    logic              start;

    // high in the cycle the answer is on the bus, so a held cyc is answered once
    logic              pending;

    logic                             ack_q;
    logic                             err_q;
    logic [wb_cmd_pkg::WB_DATA_W-1:0] dat_q;

    assign word_idx = bus_req_i.adr[ADDR_BITS-1:2];
    assign reg_idx  = word_idx[IDX_W-1:0];
    assign in_range = (word_idx < REG_WORDS);
    assign start    = bus_req_i.cyc && !pending;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pending <= 1'b0;
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
            dat_q   <= '0;
        end else begin
            pending <= start;
            ack_q   <= start && in_range;
            err_q   <= start && !in_range;
            if (start && in_range && !bus_req_i.we) begin
                dat_q <= regs[reg_idx];
            end
        end
    end

    // register array, byte-lane writes
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < REG_WORDS; i++) begin
                regs[i] <= '0;
            end
        end else if (start && in_range && bus_req_i.we) begin
            for (int b = 0; b < wb_cmd_pkg::WB_SEL_W; b++) begin
                if (bus_req_i.sel[b]) begin
                    regs[reg_idx][8*b +: 8] <= bus_req_i.dat[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        bus_rsp_o.dat = dat_q;
        bus_rsp_o.ack = ack_q;
        bus_rsp_o.err = err_q;
    end

endmodule

// ==== source/wb_rr_arbiter.sv ====
`timescale 1ns/1ns

// two-way round-robin arbiter for the shared Wishbone bus
// the grant locks on the first cycle of a request and is released by ack or err
module wb_rr_arbiter (
    input  logic                aclk,
    input  logic                aresetn,

    input  wb_cmd_pkg::wb_req_t req_a_i,
    input  wb_cmd_pkg::wb_req_t req_b_i,
    output wb_cmd_pkg::wb_rsp_t rsp_a_o,
    output wb_cmd_pkg::wb_rsp_t rsp_b_o,

    output wb_cmd_pkg::wb_req_t bus_req_o,
    input  wb_cmd_pkg::wb_rsp_t bus_rsp_i
);

    // lane encoding used by owner, last_b and grant_b: 0 is lane a, 1 is lane b
    logic busy;
    logic owner;
    logic last_b;
    logic grant_b;
    logic any_req;
    logic bus_done;

    assign any_req  = req_a_i.cyc | req_b_i.cyc;
    assign bus_done = bus_rsp_i.ack | bus_rsp_i.err;

    // pick a lane while the bus is free, then hold the owner
    always_comb begin
        if (busy) begin
            grant_b = owner;
        end else if (req_a_i.cyc && req_b_i.cyc) begin
            // both asking, serve the lane that did not go last
            grant_b = !last_b;
        end else begin
            grant_b = req_b_i.cyc;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            busy   <= 1'b0;
            owner  <= 1'b0;
            last_b <= 1'b0;
        end else if (busy) begin
            if (bus_done) begin
                busy   <= 1'b0;
                last_b <= owner;
            end
        end else if (any_req) begin
            if (bus_done) begin
                // answered in its first cycle, nothing to lock
                last_b <= grant_b;
            end else begin
                busy  <= 1'b1;
                owner <= grant_b;
            end
        end
    end

    assign bus_req_o = grant_b ? req_b_i : req_a_i;

    // read data fans out, the strobes only reach the granted lane
    always_comb begin
        rsp_a_o.dat = bus_rsp_i.dat;
        rsp_a_o.ack = bus_rsp_i.ack & !grant_b;
        rsp_a_o.err = bus_rsp_i.err & !grant_b;

        rsp_b_o.dat = bus_rsp_i.dat;
        rsp_b_o.ack = bus_rsp_i.ack & grant_b;
        rsp_b_o.err = bus_rsp_i.err & grant_b;
    end

endmodule

// ==== source/wb_cmd_master.sv ====
`timescale 1ns/1ns

// command master for one link lane
// an address word with the read flag set is a read, otherwise it is a write
// that also consumes one word from the data stream
module wb_cmd_master #(
    parameter int ADDR_BITS = 25
) (
    input  logic                                aclk,
    input  logic                                aresetn,

    input  logic [wb_cmd_pkg::WB_ADR_W-1:0]     addr_tdata_i,
    input  logic                                addr_tvalid_i,
    output logic                                addr_tready_o,

    input  logic [wb_cmd_pkg::WB_DATA_W-1:0]    data_tdata_i,
    input  logic                                data_tvalid_i,
    output logic                                data_tready_o,

    output logic [wb_cmd_pkg::WB_DATA_W-1:0]    resp_tdata_o,
    output logic                                resp_tvalid_o,
    input  logic                                resp_tready_i,

    output wb_cmd_pkg::wb_req_t                 wb_req_o,
    input  wb_cmd_pkg::wb_rsp_t                 wb_rsp_i
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WRITE_FINISH,
        READ_RESPOND
    } state_t;

    state_t state;

    // data of the most recent acked read
    logic [wb_cmd_pkg::WB_DATA_W-1:0] resp_data;
    logic addr_tready;
    logic data_tready;
    logic is_read;
    logic bus_done;

    assign is_read  = addr_tdata_i[wb_cmd_pkg::RD_FLAG_BIT];
    assign bus_done = wb_rsp_i.ack | wb_rsp_i.err;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state       <= IDLE;
            addr_tready <= 1'b0;
            data_tready <= 1'b0;
            resp_data   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // a write waits until its data word is there too
                    if (addr_tvalid_i && (is_read || data_tvalid_i)) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (bus_done) begin
                        state <= is_read ? READ_RESPOND : WRITE_FINISH;
                    end
                end
                WRITE_FINISH: state <= IDLE;
                READ_RESPOND: begin
                    if (resp_tready_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            // single-cycle pops, seen in the cycle after the bus answer
            addr_tready <= (state == ISSUE) && bus_done;
            data_tready <= (state == ISSUE) && bus_done && !is_read;

            // an err leaves the old word, so the lane repeats its last read
            if ((state == ISSUE) && wb_rsp_i.ack && is_read) begin
                resp_data <= wb_rsp_i.dat;
            end
        end
    end

    assign addr_tready_o = addr_tready;
    assign data_tready_o = data_tready;

    always_comb begin
        // byte address of the word, low two bits dropped
        wb_req_o.adr = {{(wb_cmd_pkg::WB_ADR_W-ADDR_BITS){1'b0}},
                        addr_tdata_i[ADDR_BITS-1:2], 2'b00};
        wb_req_o.we  = !is_read;
        wb_req_o.sel = {wb_cmd_pkg::WB_SEL_W{!is_read}};
        wb_req_o.dat = data_tdata_i;
        wb_req_o.cyc = (state == ISSUE);
    end

    assign resp_tvalid_o = (state == READ_RESPOND);
    assign resp_tdata_o  = resp_data;

endmodule

// ==== common/wb_cmd_pkg.sv ====
// shared Wishbone constants and bus structs for the command subsystem
package wb_cmd_pkg;

    // bus widths
    localparam int WB_DATA_W = 32;
    localparam int WB_ADR_W  = 32;
    localparam int WB_SEL_W  = WB_DATA_W / 8;

    // address word bit that marks a read command, a clear bit means write
    localparam int RD_FLAG_BIT = 31;

    // one master's request toward the bus
    // stb is not carried, it always equals cyc
    typedef struct packed {
        logic [WB_ADR_W-1:0]  adr;
        logic                 we;
        logic [WB_SEL_W-1:0]  sel;
        logic [WB_DATA_W-1:0] dat;
        logic                 cyc;
    } wb_req_t;

    // slave answer
    // exactly one of ack or err pulses per bus cycle
    typedef struct packed {
        logic [WB_DATA_W-1:0] dat;
        logic                 ack;
        logic                 err;
    } wb_rsp_t;

endpackage
